//--- design/xlate_defines.svh
// width and sizing macros for the pod translation front end
// XLATE_CORD_W must equal XLATE_POD_W + XLATE_SUB_W

`ifndef XLATE_DEFINES_SVH
`define XLATE_DEFINES_SVH

// one lane per core in the cluster
`define XLATE_NUM_LANES 4

// subcoordinate inside the pod, 4x4 tiles
`define XLATE_SUB_W 2

// pod coordinate, from the placement strap
`define XLATE_POD_W 4

// global coordinate = {pod, sub}
`define XLATE_CORD_W 6

// endpoint physical address, word granular
`define XLATE_EPA_W 28

// vcache block is 8 words
`define XLATE_BLOCK_WORDS_LG 3

// result buffer entries per lane
`define XLATE_FIFO_DEPTH 4

`endif

//--- design/xlate_pkg.sv
// shared types for the translation front end
// lane count must be 2 or more so lane_id_t has a nonzero width

`include "xlate_defines.svh"

package xlate_pkg;

  // endpoint virtual address, byte granular
  typedef logic [31:0] eva_t;

  // global mesh coordinate, pod part on top
  typedef logic [`XLATE_CORD_W-1:0] cord_t;

  // tile coordinate inside one pod
  typedef logic [`XLATE_SUB_W-1:0] sub_cord_t;

  // pod coordinate
  typedef logic [`XLATE_POD_W-1:0] pod_cord_t;

  // word address at the endpoint
  typedef logic [`XLATE_EPA_W-1:0] epa_t;

  // index of a core / lane
  typedef logic [$clog2(`XLATE_NUM_LANES)-1:0] lane_id_t;

endpackage

//--- design/xlate_if.sv
// request and result links between dispatcher, lanes and arbiter
// valid is a single cycle strobe, there is no ready anywhere

// dispatcher -> lane
interface xlate_req_if
  import xlate_pkg::*;
();

  logic      valid;  // request strobe
  eva_t      eva;    // byte address from the core
  sub_cord_t tgo_x;  // tile-group origin of the issuing core
  sub_cord_t tgo_y;

  modport src (output valid, output eva, output tgo_x, output tgo_y);
  modport snk (input valid, input eva, input tgo_x, input tgo_y);

endinterface

// lane -> arbiter
interface xlate_res_if
  import xlate_pkg::*;
();

  logic  valid;    // result strobe, one cycle after the request
  cord_t x_cord;   // destination x, global
  cord_t y_cord;   // destination y, global
  epa_t  epa;      // word address at the destination
  logic  invalid;  // eva matched no remote class

  modport src (
    output valid, output x_cord, output y_cord, output epa, output invalid
  );
  modport snk (
    input valid, input x_cord, input y_cord, input epa, input invalid
  );

endinterface

//--- design/tgo_dispatch.sv
// per-core tile-group origins and request fan-out, combinational to the lanes
// a cfg write lands at the clock edge, same-cycle requests see the old origin

`include "xlate_defines.svh"

module tgo_dispatch
  import xlate_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,

  // core requests
  input  logic [`XLATE_NUM_LANES-1:0] req_valid_i,
  input  eva_t                        req_eva_i [`XLATE_NUM_LANES],

  // origin config, one core per strobe
  input  logic                        cfg_valid_i,
  input  lane_id_t                    cfg_lane_i,
  input  sub_cord_t                   cfg_tgo_x_i,
  input  sub_cord_t                   cfg_tgo_y_i,

  // one request link per lane
  xlate_req_if.src                    req_o [`XLATE_NUM_LANES]
);

  localparam int num_lanes_lp = `XLATE_NUM_LANES;

  // origin registers, one pair per core
  sub_cord_t tgo_x_r [num_lanes_lp];
  sub_cord_t tgo_y_r [num_lanes_lp];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int l = 0; l < num_lanes_lp; l++) begin
        tgo_x_r[l] <= '0;  // origin back to tile 0,0
        tgo_y_r[l] <= '0;
      end
    end else if (cfg_valid_i) begin
      tgo_x_r[cfg_lane_i] <= cfg_tgo_x_i;
      tgo_y_r[cfg_lane_i] <= cfg_tgo_y_i;
    end
  end

  // core g always talks to lane g
  for (genvar g = 0; g < num_lanes_lp; g++) begin : g_fan
    assign req_o[g].valid = req_valid_i[g];
    assign req_o[g].eva   = req_eva_i[g];
    assign req_o[g].tgo_x = tgo_x_r[g];  // registered value, not the cfg bypass
    assign req_o[g].tgo_y = tgo_y_r[g];
  end

  // config must address a real core, else the write is lost silently
  a_cfg_lane_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cfg_valid_i |-> (int'(cfg_lane_i) < num_lanes_lp)
  ) else $error("cfg_lane_i out of range");

endmodule

//--- design/eva_to_npa_lane.sv
// one translation lane, eva in cycle t gives a registered npa in cycle t+1
// dram striping covers one vcache row north and one south only

`include "xlate_defines.svh"

module eva_to_npa_lane
  import xlate_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  pod_cord_t pod_x_i,  // placement strap
  input  pod_cord_t pod_y_i,
  xlate_req_if.snk  req_i,
  xlate_res_if.src  res_o
);

  localparam int blk_lg_lp   = `XLATE_BLOCK_WORDS_LG;
  localparam int sub_w_lp    = `XLATE_SUB_W;
  localparam int strip_w_lp  = sub_w_lp + 1;  // column bits plus side bit
  localparam int dram_w_lp   = 29;            // word addr bits 30..2

  eva_t eva;
  assign eva = req_i.eva;

  // raw class hits
  logic is_dram;
  logic is_global;
  logic is_tg;

  assign is_dram   = eva[31];
  assign is_global = (eva[31:30] == 2'b01);
  assign is_tg     = (eva[31:29] == 3'b001);

  // after priority dram > global > tile-group > invalid
  logic sel_dram;
  logic sel_global;
  logic sel_tg;
  logic sel_inv;

  assign sel_dram   = is_dram;
  assign sel_global = !is_dram && is_global;
  assign sel_tg     = !is_dram && !is_global && is_tg;
  assign sel_inv    = !(is_dram || is_global || is_tg);

  // dram stripe hash
  logic [dram_w_lp-1:0]              dram_word;
  logic [dram_w_lp-blk_lg_lp-1:0]    blk_idx;   // vcache block number
  logic [sub_w_lp-1:0]               dram_col;  // vcache column in the row
  logic                              dram_side; // 0 north, 1 south
  epa_t                              dram_epa;

  assign dram_word = eva[30:2];
  assign blk_idx   = dram_word[dram_w_lp-1:blk_lg_lp];
  assign dram_col  = blk_idx[sub_w_lp-1:0];
  assign dram_side = blk_idx[sub_w_lp];
  // squeeze out the stripe bits, keep the offset inside the block
  assign dram_epa  = epa_t'({dram_word[dram_w_lp-1:blk_lg_lp+strip_w_lp],
                             dram_word[blk_lg_lp-1:0]});

  // tile-group offsets wrap inside the pod
  sub_cord_t tg_x_sum;
  sub_cord_t tg_y_sum;

  assign tg_x_sum = sub_cord_t'(eva[22:21] + req_i.tgo_x);
  assign tg_y_sum = sub_cord_t'(eva[24:23] + req_i.tgo_y);

  // next result
  cord_t x_nxt;
  cord_t y_nxt;
  epa_t  epa_nxt;

  always_comb begin
    x_nxt   = '0;  // invalid class leaves all zero
    y_nxt   = '0;
    epa_nxt = '0;
    if (sel_dram) begin
      x_nxt   = {pod_x_i, dram_col};
      y_nxt   = {pod_y_i, {sub_w_lp{dram_side}}};  // 00 north row, 11 south row
      epa_nxt = dram_epa;
    end else if (sel_global) begin
      // coordinates carried directly in the eva
      y_nxt   = cord_t'(eva[29:24]);
      x_nxt   = cord_t'(eva[23:18]);
      epa_nxt = epa_t'(eva[17:2]);
    end else if (sel_tg) begin
      x_nxt   = {pod_x_i, tg_x_sum};
      y_nxt   = {pod_y_i, tg_y_sum};
      epa_nxt = epa_t'(eva[17:2]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) res_o.valid <= 1'b0;
    else       res_o.valid <= req_i.valid;
  end

  // payload only moves on a request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      res_o.x_cord  <= x_nxt;
      res_o.y_cord  <= y_nxt;
      res_o.epa     <= epa_nxt;
      res_o.invalid <= sel_inv;
    end
  end

  a_one_class: assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_i.valid |-> $onehot({sel_dram, sel_global, sel_tg, sel_inv})
  ) else $error("class decode not one-hot");

endmodule

//--- design/npa_drain_arbiter.sv
// per-lane result FIFOs drained round-robin, at most one npa per cycle
// several drops in one cycle report only the lowest lane id

`include "xlate_defines.svh"

module npa_drain_arbiter
  import xlate_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  xlate_res_if.snk res_i [`XLATE_NUM_LANES],
  output logic     out_valid_o,
  output lane_id_t out_lane_o,
  output cord_t    out_x_cord_o,
  output cord_t    out_y_cord_o,
  output epa_t     out_epa_o,
  output logic     out_invalid_o,
  output logic     drop_o,       // result lost to a full FIFO this cycle
  output lane_id_t drop_lane_o
);

  localparam int num_lanes_lp = `XLATE_NUM_LANES;
  localparam int depth_lp     = `XLATE_FIFO_DEPTH;
  localparam int ptr_w_lp     = $clog2(depth_lp);
  localparam int cnt_w_lp     = $clog2(depth_lp + 1);
  localparam int ent_w_lp     = 2 * `XLATE_CORD_W + `XLATE_EPA_W + 1;

  logic [num_lanes_lp-1:0] in_valid;
  logic [ent_w_lp-1:0]     in_data [num_lanes_lp];  // {x, y, epa, invalid}

  for (genvar g = 0; g < num_lanes_lp; g++) begin : g_in
    assign in_valid[g] = res_i[g].valid;
    assign in_data[g]  = {res_i[g].x_cord, res_i[g].y_cord, res_i[g].epa, res_i[g].invalid};
  end

  logic [ent_w_lp-1:0] mem [num_lanes_lp][depth_lp];
  logic [ptr_w_lp-1:0] wr_ptr [num_lanes_lp];
  logic [ptr_w_lp-1:0] rd_ptr [num_lanes_lp];
  logic [cnt_w_lp-1:0] count [num_lanes_lp];
  lane_id_t            rr_last;  // lane served most recently

  logic [num_lanes_lp-1:0] not_empty;
  logic [num_lanes_lp-1:0] full;
  logic [num_lanes_lp-1:0] rd_en;
  logic [num_lanes_lp-1:0] wr_en;
  logic [num_lanes_lp-1:0] drop_vec;
  lane_id_t                sel;
  logic                    sel_valid;

  for (genvar g = 0; g < num_lanes_lp; g++) begin : g_flags
    assign not_empty[g] = (count[g] != '0);
    assign full[g]      = (count[g] == cnt_w_lp'(depth_lp));
  end

  // search starts one past rr_last, nearest non-empty wins
  always_comb begin
    int cand;
    sel       = rr_last;
    sel_valid = 1'b0;
    rd_en     = '0;
    for (int k = num_lanes_lp; k >= 1; k--) begin
      cand = (int'(rr_last) + k) % num_lanes_lp;
      if (not_empty[cand]) begin
        sel       = lane_id_t'(cand);
        sel_valid = 1'b1;
      end
    end
    if (sel_valid) rd_en[sel] = 1'b1;
  end

  assign wr_en    = in_valid & (~full | rd_en);  // same-cycle read frees a slot
  assign drop_vec = in_valid & full & ~rd_en;

  always_comb begin
    drop_lane_o = '0;
    for (int l = num_lanes_lp - 1; l >= 0; l--) begin
      if (drop_vec[l]) drop_lane_o = lane_id_t'(l);
    end
  end

  assign drop_o        = |drop_vec;
  assign out_valid_o   = sel_valid;
  assign out_lane_o    = sel;
  assign {out_x_cord_o, out_y_cord_o, out_epa_o, out_invalid_o} = mem[sel][rd_ptr[sel]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int l = 0; l < num_lanes_lp; l++) begin
        wr_ptr[l] <= '0;
        rd_ptr[l] <= '0;
        count[l]  <= '0;
      end
      rr_last <= lane_id_t'(num_lanes_lp - 1);  // so lane 0 goes first
    end else begin
      for (int l = 0; l < num_lanes_lp; l++) begin
        if (wr_en[l]) wr_ptr[l] <= (wr_ptr[l] == ptr_w_lp'(depth_lp - 1)) ? '0 : wr_ptr[l] + 1'b1;
        if (rd_en[l]) rd_ptr[l] <= (rd_ptr[l] == ptr_w_lp'(depth_lp - 1)) ? '0 : rd_ptr[l] + 1'b1;
        count[l] <= count[l] + cnt_w_lp'(wr_en[l]) - cnt_w_lp'(rd_en[l]);
      end
      if (sel_valid) rr_last <= sel;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int l = 0; l < num_lanes_lp; l++) begin
      if (wr_en[l]) mem[l][wr_ptr[l]] <= in_data[l];
    end
  end

  for (genvar g = 0; g < num_lanes_lp; g++) begin : g_chk
    a_count_bound: assert property (
      @(posedge clk_i) disable iff (rst_i) count[g] <= cnt_w_lp'(depth_lp)
    ) else $error("FIFO count over depth");
  end

  a_emit_nonempty: assert property (
    @(posedge clk_i) disable iff (rst_i) out_valid_o |-> (count[out_lane_o] != '0)
  ) else $error("emit from empty FIFO");

endmodule

//--- design/eva_xlate_top.sv
// translation front end for one pod cluster, no back-pressure toward the network
// request to out_valid_o takes two cycles at least, more under contention

`include "xlate_defines.svh"

module eva_xlate_top
  import xlate_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`XLATE_NUM_LANES-1:0] req_valid_i,  // one bit per core
  input  eva_t                        req_eva_i [`XLATE_NUM_LANES],
  input  logic                        cfg_valid_i,
  input  lane_id_t                    cfg_lane_i,
  input  sub_cord_t                   cfg_tgo_x_i,
  input  sub_cord_t                   cfg_tgo_y_i,
  input  pod_cord_t                   pod_x_i,      // static strap
  input  pod_cord_t                   pod_y_i,
  output logic                        out_valid_o,
  output lane_id_t                    out_lane_o,
  output cord_t                       out_x_cord_o,
  output cord_t                       out_y_cord_o,
  output epa_t                        out_epa_o,
  output logic                        out_invalid_o,
  output logic                        drop_o,
  output lane_id_t                    drop_lane_o
);

  xlate_req_if req_if [`XLATE_NUM_LANES] ();
  xlate_res_if res_if [`XLATE_NUM_LANES] ();

  tgo_dispatch u_dispatch (
    .clk_i, .rst_i, .req_valid_i, .req_eva_i,
    .cfg_valid_i, .cfg_lane_i, .cfg_tgo_x_i, .cfg_tgo_y_i,
    .req_o (req_if)
  );

  // identical lanes, core g to lane g
  for (genvar g = 0; g < `XLATE_NUM_LANES; g++) begin : g_lane
    eva_to_npa_lane u_lane (
      .clk_i, .rst_i, .pod_x_i, .pod_y_i,
      .req_i (req_if[g]),
      .res_o (res_if[g])
    );
  end

  npa_drain_arbiter u_arb (
    .clk_i, .rst_i,
    .res_i (res_if),
    .out_valid_o, .out_lane_o, .out_x_cord_o, .out_y_cord_o,
    .out_epa_o, .out_invalid_o, .drop_o, .drop_lane_o
  );

endmodule

//--- bench/xlate_model.svh
// reference model of the address map, lane FIFOs and round-robin drain
// included inside xlate_tb, uses its strap, request and output signals

`ifndef XLATE_MODEL_SVH
`define XLATE_MODEL_SVH

localparam int ent_w_lp = 2 * `XLATE_CORD_W + `XLATE_EPA_W + 1;
localparam int lanes_lp = `XLATE_NUM_LANES;
localparam int depth_lp = `XLATE_FIFO_DEPTH;

typedef logic [ent_w_lp-1:0] entry_t;  // {x, y, epa, invalid}

sub_cord_t tgo_x_m [lanes_lp];       // origin mirror
sub_cord_t tgo_y_m [lanes_lp];
entry_t    fifo_m [lanes_lp][$];     // per-lane result buffer
logic      lres_valid_m [lanes_lp];  // lane output register
entry_t    lres_data_m [lanes_lp];
int        rr_last_m;                // lane served last

// address map straight from the rules
function automatic entry_t expected_npa(eva_t eva, sub_cord_t tx, sub_cord_t ty);
  logic [28:0] word;
  logic [25:0] blk;
  cord_t       x;
  cord_t       y;
  epa_t        epa;
  logic        inv;
  word = eva[30:2];
  blk  = word[28:3];  // block index, 8 words per block
  x    = '0;
  y    = '0;
  epa  = '0;
  inv  = 1'b0;
  if (eva[31] == 1'b1) begin
    x   = {pod_x, blk[1:0]};
    y   = {pod_y, (blk[2] ? 2'b11 : 2'b00)};  // south row or north row
    epa = (epa_t'(word >> 6) << 3) | epa_t'(word[2:0]);
  end else if (eva[31:30] == 2'b01) begin
    y   = eva[29:24];
    x   = eva[23:18];
    epa = epa_t'(eva[17:2]);
  end else if (eva[31:29] == 3'b001) begin
    x   = {pod_x, sub_cord_t'(eva[22:21] + tx)};  // wraps inside the pod
    y   = {pod_y, sub_cord_t'(eva[24:23] + ty)};
    epa = epa_t'(eva[17:2]);
  end else begin
    inv = 1'b1;
  end
  return {x, y, epa, inv};
endfunction

task automatic clear_mirror();
  for (int l = 0; l < lanes_lp; l++) begin
    fifo_m[l].delete();
    lres_valid_m[l] = 1'b0;
    tgo_x_m[l]      = '0;
    tgo_y_m[l]      = '0;
  end
  rr_last_m = lanes_lp - 1;  // lane 0 first after reset
endtask

// one clock cycle: check outputs, then move the model state
task automatic advance_model();
  int     sel;
  int     cand;
  bit     found;
  bit     dropped;
  int     drop_lane;
  entry_t head;
  cord_t  ex;
  cord_t  ey;
  epa_t   eepa;
  logic   einv;
  found     = 1'b0;
  sel       = 0;
  dropped   = 1'b0;
  drop_lane = 0;
  for (int k = 1; k <= lanes_lp; k++) begin
    cand = (rr_last_m + k) % lanes_lp;
    if (!found && fifo_m[cand].size() != 0) begin
      found = 1'b1;
      sel   = cand;
    end
  end
  check_value("out_valid_o", 64'(out_valid), 64'(found));
  if (found) begin
    head                   = fifo_m[sel].pop_front();
    {ex, ey, eepa, einv}   = head;
    rr_last_m              = sel;
    check_value("out_lane_o", 64'(out_lane), 64'(sel));
    check_value("out_x_cord_o", 64'(out_x), 64'(ex));
    check_value("out_y_cord_o", 64'(out_y), 64'(ey));
    check_value("out_epa_o", 64'(out_epa), 64'(eepa));
    check_value("out_invalid_o", 64'(out_inv), 64'(einv));
  end
  // writes land after the read has freed its slot
  for (int l = 0; l < lanes_lp; l++) begin
    if (lres_valid_m[l]) begin
      if (fifo_m[l].size() < depth_lp) begin
        fifo_m[l].push_back(lres_data_m[l]);
      end else if (!dropped) begin
        dropped   = 1'b1;
        drop_lane = l;  // lowest lane reported
      end
    end
  end
  check_value("drop_o", 64'(drop), 64'(dropped));
  if (dropped) check_value("drop_lane_o", 64'(drop_lane_s), 64'(drop_lane));
  // this cycle's requests use the origin before any cfg write
  for (int l = 0; l < lanes_lp; l++) begin
    lres_valid_m[l] = req_valid[l];
    if (req_valid[l]) lres_data_m[l] = expected_npa(req_eva[l], tgo_x_m[l], tgo_y_m[l]);
  end
  if (cfg_valid) begin
    tgo_x_m[cfg_lane] = cfg_tgo_x;
    tgo_y_m[cfg_lane] = cfg_tgo_y;
  end
endtask

function automatic bit model_drained();
  bit idle;
  idle = 1'b1;
  for (int l = 0; l < lanes_lp; l++) begin
    if (fifo_m[l].size() != 0 || lres_valid_m[l]) idle = 1'b0;
  end
  return idle;
endfunction

`endif

//--- bench/xlate_tb.sv
// random xorshift stimulus against eva_xlate_top, model checked every cycle
// outputs are sampled at the falling edge, inputs move 10 units after the rising edge

`include "xlate_defines.svh"

module xlate_tb
  import xlate_pkg::*;
();

  localparam int period_lp        = 100;
  localparam int reset_cycles_lp  = 10;
  localparam int idle_cycles_lp   = 5;
  localparam int class_cycles_lp  = 60;
  localparam int tg_cycles_lp     = 60;
  localparam int order_cycles_lp  = 40;
  localparam int burst_cycles_lp  = 12;
  localparam int drain_cycles_lp  = 40;
  localparam int margin_cycles_lp = 20;
  localparam int total_cycles_lp  = reset_cycles_lp + idle_cycles_lp + class_cycles_lp
                                    + tg_cycles_lp + order_cycles_lp + burst_cycles_lp
                                    + drain_cycles_lp;

  logic                        clk;
  logic                        rst;
  logic [`XLATE_NUM_LANES-1:0] req_valid;
  eva_t                        req_eva [`XLATE_NUM_LANES];
  logic                        cfg_valid;
  lane_id_t                    cfg_lane;
  sub_cord_t                   cfg_tgo_x;
  sub_cord_t                   cfg_tgo_y;
  pod_cord_t                   pod_x;  // strap, fixed for the run
  pod_cord_t                   pod_y;
  logic                        out_valid;
  lane_id_t                    out_lane;
  cord_t                       out_x;
  cord_t                       out_y;
  epa_t                        out_epa;
  logic                        out_inv;
  logic                        drop;
  lane_id_t                    drop_lane_s;

  logic [31:0] rng_state = 32'd976;

  eva_xlate_top DUT (
    .clk_i (clk), .rst_i (rst),
    .req_valid_i (req_valid), .req_eva_i (req_eva),
    .cfg_valid_i (cfg_valid), .cfg_lane_i (cfg_lane),
    .cfg_tgo_x_i (cfg_tgo_x), .cfg_tgo_y_i (cfg_tgo_y),
    .pod_x_i (pod_x), .pod_y_i (pod_y),
    .out_valid_o (out_valid), .out_lane_o (out_lane),
    .out_x_cord_o (out_x), .out_y_cord_o (out_y),
    .out_epa_o (out_epa), .out_invalid_o (out_inv),
    .drop_o (drop), .drop_lane_o (drop_lane_s)
  );

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  `include "xlate_model.svh"

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // kind 0 dram, 1 global, 2 tile-group, 3 invalid
  function automatic eva_t make_eva(logic [1:0] kind, logic [31:0] rnd);
    case (kind)
      2'd0:    return {1'b1, rnd[30:0]};
      2'd1:    return {2'b01, rnd[29:0]};
      2'd2:    return {3'b001, rnd[28:0]};
      default: return {3'b000, rnd[28:0]};
    endcase
  endfunction

  // next drive point, strobes cleared
  task automatic step_cycle();
    @(posedge clk);
    #10;
    req_valid = '0;
    cfg_valid = 1'b0;
  endtask

  initial clk = 1'b0;
  always #(period_lp / 2) clk = ~clk;

  always @(negedge clk) begin
    if (rst) clear_mirror();
    else     advance_model();
  end

  initial begin
    #(period_lp * (total_cycles_lp + margin_cycles_lp));
    $display("ERROR: watchdog expired before the run finished");
    $display("Test failed");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] r;
    lane_id_t    lane;
    bit          idle_ok;
    rst       = 1'b1;
    req_valid = '0;
    cfg_valid = 1'b0;
    cfg_lane  = '0;
    cfg_tgo_x = '0;
    cfg_tgo_y = '0;
    for (int l = 0; l < `XLATE_NUM_LANES; l++) req_eva[l] = '0;
    r     = next_rand();
    pod_x = r[3:0];
    pod_y = r[7:4];
    repeat (reset_cycles_lp) @(posedge clk);
    #10 rst = 1'b0;

    repeat (idle_cycles_lp) step_cycle();  // outputs must stay quiet

    // single lane, low rate, dram / global / invalid
    repeat (class_cycles_lp) begin
      step_cycle();
      r = next_rand();
      if (r[1:0] == 2'b00) begin
        lane               = r[3:2];
        req_valid[lane]    = 1'b1;
        req_eva[lane]      = make_eva((r[5:4] == 2'd2) ? 2'd3 : r[5:4], next_rand());
      end
    end

    // tile-group with origin writes, often on the same lane same cycle
    repeat (tg_cycles_lp) begin
      step_cycle();
      r = next_rand();
      if (r[0]) begin
        cfg_valid = 1'b1;
        cfg_lane  = r[2:1];
        cfg_tgo_x = r[4:3];
        cfg_tgo_y = r[6:5];
      end
      if (r[7]) begin
        lane            = r[8] ? r[2:1] : r[10:9];
        req_valid[lane] = 1'b1;
        req_eva[lane]   = make_eva(2'd2, next_rand());
      end
    end

    // several lanes at once, any class
    repeat (order_cycles_lp) begin
      step_cycle();
      r = next_rand();
      for (int l = 0; l < `XLATE_NUM_LANES; l++) begin
        if (r[l]) begin
          req_valid[l] = 1'b1;
          req_eva[l]   = make_eva(r[8+2*l +: 2], next_rand());
        end
      end
    end

    // every lane every cycle, FIFOs overflow
    repeat (burst_cycles_lp) begin
      step_cycle();
      r         = next_rand();
      req_valid = '1;
      for (int l = 0; l < `XLATE_NUM_LANES; l++) req_eva[l] = make_eva(r[2*l +: 2], next_rand());
    end

    repeat (drain_cycles_lp) step_cycle();
    @(negedge clk);
    #1;
    idle_ok = model_drained() && out_valid === 1'b0;
    assert (idle_ok) else $display("ERROR: output did not drain to idle after the burst");
    if (idle_ok) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "not idle");
    end
  end

endmodule

//--- list.f
+incdir+design
+incdir+bench
design/xlate_pkg.sv
design/xlate_if.sv
design/tgo_dispatch.sv
design/eva_to_npa_lane.sv
design/npa_drain_arbiter.sv
design/eva_xlate_top.sv
bench/xlate_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module xlate_tb -o xlate_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/xlate_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
echo "pass line missing from simulation output"
exit 1
